/* all.f */
+incdir+common
common/fetch_pkg.sv
common/instr_pkg.sv
hw/fetch/fetch_request.sv
hw/fetch/prefetch_queue.sv
hw/assembly/instr_assembly.sv
hw/regs_predecode.sv
hw/frontend_top.sv
verification/tb_frontend.sv

/* run.sh */
#!/bin/sh
# build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_frontend \
	-Mdir obj_dir -o sim_frontend
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_frontend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST FAILED ***' sim.log; then
	exit 1
fi
if ! grep -qF '*** TEST PASSED ***' sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

/* verification/tb_frontend.sv */
// testbench for frontend_top with a one-cycle memory model and a random decode model
// program memory is 1024 halfwords and wraps, jump targets stay inside it
// inputs are driven 1 ns after the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ps
`default_nettype none

`include "frontend_macros.svh"

module tb_frontend import fetch_pkg::*, instr_pkg::*; ();

	localparam int MEM_HALVES  = 1024;
	localparam int SEQ_CYCLES  = 600;
	localparam int IDLE_CYCLES = 80;
	localparam int STALL_RUN   = 200;
	localparam int JUMP_CYCLES = 900;
	localparam int TEST_CYCLES = 60 + SEQ_CYCLES + IDLE_CYCLES + STALL_RUN + JUMP_CYCLES;

	logic      clk;
	logic      rst_n;
	addr_t     mem_addr;
	logic      mem_addr_vld;
	logic      mem_addr_rdy;
	word_t     mem_data;
	logic      mem_data_vld;
	addr_t     jump_target;
	logic      jump_target_vld;
	logic      jump_target_rdy;
	word_t     cir;
	hw_count_t cir_vld;
	hw_count_t cir_use;
	reg_num_t  next_regs_rs1;
	reg_num_t  next_regs_rs2;
	logic      next_regs_vld;

	half_t    prog [MEM_HALVES];
	integer   seed;
	int       errors = 0;
	int       checks = 0;
	int       consumed = 0;
	int       jumps = 0;
	int       pd_checks = 0;
	int       pd_errors = 0;
	int       bus_errors = 0;
	// decode model state, pc is the address of the instruction in cir
	addr_t    pc;
	addr_t    cir_pc;
	addr_t    jump_dest;
	logic     jump_taken = 1'b0;
	logic     consume_en = 1'b0;
	logic     jumps_en = 1'b0;
	// bus monitor state
	logic     accept_d = 1'b0;
	addr_t    accept_addr;
	logic     hold_prev = 1'b0;
	addr_t    held_addr;
	logic     data_seen = 1'b0;
	logic     first_accept = 1'b0;
	logic     after_reset = 1'b0;
	logic     pd_saved = 1'b0;
	reg_num_t pd_rs1;
	reg_num_t pd_rs2;

	frontend_top i_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_use         (cir_use),
		.next_regs_rs1   (next_regs_rs1),
		.next_regs_rs2   (next_regs_rs2),
		.next_regs_vld   (next_regs_vld)
	);

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	// instruction at a byte address, the upper half is zero for compressed ones
	function automatic word_t instr_at(input addr_t a);
		logic [9:0] idx;
		half_t      lo;
		half_t      hi;
		idx = a[10:1];
		lo  = prog[idx];
		hi  = prog[idx + 10'd1];
		return (lo[1:0] == 2'b11) ? {hi, lo} : {16'h0000, lo};
	endfunction

	// whole bus word at a word aligned address, low halfword first
	function automatic word_t bus_word(input addr_t a);
		logic [9:0] idx;
		idx = a[10:1];
		return {prog[idx + 10'd1], prog[idx]};
	endfunction

	// expected {rs1, rs2} of one instruction
	function automatic logic [9:0] ref_regs(input word_t w);
		logic [1:0] q;
		logic [2:0] f3;
		reg_num_t   rs1;
		reg_num_t   rs2;
		q  = w[1:0];
		f3 = w[15:13];
		if (q == 2'b11) begin
			rs1 = w[19:15];
			rs2 = w[24:20];
		end else begin
			// stack pointer forms first, then full fields, then x8 based fields
			if ((q == 2'b00 && f3 == 3'd0) || (q == 2'b01 && f3 == 3'd3)
				|| (q == 2'b10 && (f3 == 3'd2 || f3 == 3'd6))) begin
				rs1 = 5'd2;
			end else if (q == 2'b10 || (q == 2'b01 && f3 == 3'd0)) begin
				rs1 = w[11:7];
			end else begin
				rs1 = {2'b01, w[9:7]};
			end
			rs2 = (q == 2'b10) ? w[6:2] : {2'b01, w[4:2]};
		end
		return {rs1, rs2};
	endfunction

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic compare_reg(input string name, input reg_num_t got, input reg_num_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_fail(input string what);
		errors++;
		$display("Error: %s at %0t", what, $time);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------
	// input drive, memory data and decode consumption
	// ------------------------------------------------------------

	always begin : drive_inputs
		int    len_h;
		word_t exp;
		word_t got;
		@(posedge clk);
		#1;
		mem_addr_rdy = ($random(seed) & 3) != 0;
		// data comes back exactly one cycle after the address was taken
		mem_data_vld = accept_d;
		mem_data     = accept_d ? bus_word(accept_addr) : word_t'($random(seed));
		if (jump_taken) begin
			jump_target_vld = 1'b0;
			pc              = jump_dest;
			jump_taken      = 1'b0;
		end
		cir_use = 2'd0;
		cir_pc  = pc;
		if (!jump_target_vld && consume_en && cir_vld != 2'd0 && ($random(seed) & 7) != 0) begin
			len_h = (cir[1:0] == 2'b11) ? 2 : 1;
			if (int'(cir_vld) >= len_h) begin
				exp = instr_at(pc);
				got = (cir[1:0] == 2'b11) ? cir : {16'h0000, cir[15:0]};
				compare_word("cir", got, exp);
				cir_use = hw_count_t'(len_h);
				pc      = pc + ((exp[1:0] == 2'b11) ? 32'd4 : 32'd2);
				consumed++;
				// now and then the consumed instruction acts as a jump
				if (jumps_en && ($random(seed) & 7) == 0) begin
					jump_dest       = addr_t'($random(seed)) & 32'h0000_07fc;
					jump_target     = jump_dest;
					jump_target_vld = 1'b1;
					jumps++;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// output monitor on the falling edge
	// ------------------------------------------------------------

	always @(negedge clk) begin : monitor
		int         e0;
		logic       covers;
		logic [9:0] exp_regs;
		if (rst_n) begin
			e0 = errors;
			if (!after_reset && mem_addr_vld) begin
				report_fail("mem_addr_vld high in the first cycle after reset");
			end
			after_reset = 1'b1;
			if (!data_seen && cir_vld != 2'd0) begin
				report_fail("cir_vld nonzero before any data returned");
			end
			if (mem_data_vld) begin
				data_seen = 1'b1;
			end
			// a stalled address phase must hold both valid and address
			if (hold_prev) begin
				if (!mem_addr_vld) begin
					report_fail("address phase dropped before mem_addr_rdy");
				end else begin
					compare_word("mem_addr", mem_addr, held_addr);
				end
			end
			hold_prev   = mem_addr_vld && !mem_addr_rdy;
			held_addr   = mem_addr;
			accept_d    = mem_addr_vld && mem_addr_rdy;
			accept_addr = mem_addr;
			if (accept_d && !first_accept) begin
				compare_word("mem_addr", mem_addr, `FE_RESET_VECTOR);
				first_accept = 1'b1;
			end
			bus_errors += errors - e0;
			if (jump_target_vld && jump_target_rdy) begin
				jump_taken = 1'b1;
			end
			// predecode from last cycle must match the instruction now in cir
			e0     = errors;
			covers = cir_vld != 2'd0 && (cir[1:0] != 2'b11 || cir_vld == 2'd2);
			if (pd_saved && !jump_target_vld && covers) begin
				exp_regs = ref_regs(instr_at(cir_pc));
				compare_reg("next_regs_rs1", pd_rs1, exp_regs[9:5]);
				compare_reg("next_regs_rs2", pd_rs2, exp_regs[4:0]);
				pd_checks++;
			end
			pd_errors += errors - e0;
			pd_saved = next_regs_vld && !jump_target_vld;
			pd_rs1   = next_regs_rs1;
			pd_rs2   = next_regs_rs2;
		end
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------

	initial begin
		int e0;
		int c0;
		seed            = 32'hf706;
		rst_n           = 1'b0;
		mem_addr_rdy    = 1'b0;
		mem_data        = '0;
		mem_data_vld    = 1'b0;
		jump_target     = '0;
		jump_target_vld = 1'b0;
		cir_use         = 2'd0;
		pc              = `FE_RESET_VECTOR;
		cir_pc          = `FE_RESET_VECTOR;
		for (int i = 0; i < MEM_HALVES; i++) begin
			prog[i] = half_t'($random(seed));
		end
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		e0 = errors;
		for (int i = 0; i < 50 && !data_seen; i++) begin
			@(posedge clk);
		end
		if (!data_seen) begin
			report_fail("no fetch data returned after reset");
		end
		$display("test reset: %0d errors", errors - e0);

		e0 = errors;
		c0 = consumed;
		consume_en = 1'b1;
		repeat (SEQ_CYCLES) @(posedge clk);
		if (consumed == c0) begin
			report_fail("sequential stream consumed no instruction");
		end
		$display("test sequential: %0d instructions, %0d errors", consumed - c0, errors - e0);

		// decode idles so the queue fills, then the stream must go on unbroken
		e0 = errors;
		c0 = consumed;
		consume_en = 1'b0;
		repeat (IDLE_CYCLES) @(posedge clk);
		// by now the yard and the queue are full, so no request may be shown
		@(negedge clk);
		if (mem_addr_vld) begin
			report_fail("fetch requests went on while decode consumed nothing");
		end
		consume_en = 1'b1;
		repeat (STALL_RUN) @(posedge clk);
		if (consumed == c0) begin
			report_fail("stream did not resume after decode stall");
		end
		$display("test stall: %0d instructions, %0d errors", consumed - c0, errors - e0);

		e0 = errors;
		c0 = consumed;
		jumps_en = 1'b1;
		repeat (JUMP_CYCLES) @(posedge clk);
		jumps_en = 1'b0;
		while (jump_target_vld) begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk);
		if (jumps == 0) begin
			report_fail("no jump was taken");
		end
		$display("test jumps: %0d jumps, %0d instructions, %0d errors",
			jumps, consumed - c0, errors - e0);

		if (pd_checks == 0) begin
			report_fail("predecode was never checked");
			pd_errors++;
		end
		$display("test predecode: %0d checks, %0d errors", pd_checks, pd_errors);
		$display("test bus protocol: %0d errors", bus_errors);

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog sized from the test lengths
	initial begin
		#(TEST_CYCLES * 20 + 500);
		$display("Error: watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/frontend_top.sv */
// instruction fetch front end, bus request, prefetch queue, CIR assembly and
// register predecode, jump targets must be word aligned
`timescale 1ns/1ps
`default_nettype none

module frontend_top import fetch_pkg::*; import instr_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	output addr_t          mem_addr,
	output logic           mem_addr_vld,
	input  wire logic      mem_addr_rdy,
	input  wire word_t     mem_data,
	input  wire logic      mem_data_vld,
	input  wire addr_t     jump_target,
	input  wire logic      jump_target_vld,
	output logic           jump_target_rdy,
	output word_t          cir,
	output hw_count_t      cir_vld,
	input  wire hw_count_t cir_use,
	output reg_num_t       next_regs_rs1,
	output reg_num_t       next_regs_rs2,
	output logic           next_regs_vld
);

	logic        jump_now;
	logic        flushing;
	logic        queue_full;
	logic        queue_almost_full;
	logic        must_refill;
	word_t       fetch_data;
	logic        fetch_data_vld;
	instr_view_u next_instr;
	hw_count_t   next_level;

	fetch_request i_fetch_request (
		.clk               (clk),
		.rst_n             (rst_n),
		.mem_addr          (mem_addr),
		.mem_addr_vld      (mem_addr_vld),
		.mem_addr_rdy      (mem_addr_rdy),
		.mem_data_vld      (mem_data_vld),
		.jump_target       (jump_target),
		.jump_target_vld   (jump_target_vld),
		.jump_target_rdy   (jump_target_rdy),
		.queue_full        (queue_full),
		.queue_almost_full (queue_almost_full),
		.jump_now          (jump_now),
		.flushing          (flushing)
	);

	prefetch_queue i_prefetch_queue (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_data       (mem_data),
		.mem_data_vld   (mem_data_vld),
		.flushing       (flushing),
		.jump_now       (jump_now),
		.must_refill    (must_refill),
		.full           (queue_full),
		.almost_full    (queue_almost_full),
		.empty          (),
		.fetch_data     (fetch_data),
		.fetch_data_vld (fetch_data_vld)
	);

	instr_assembly i_instr_assembly (
		.clk            (clk),
		.rst_n          (rst_n),
		.fetch_data     (fetch_data),
		.fetch_data_vld (fetch_data_vld),
		.jump_now       (jump_now),
		.flushing       (flushing),
		.cir_use        (cir_use),
		.cir            (cir),
		.cir_vld        (cir_vld),
		.must_refill    (must_refill),
		.next_instr     (next_instr),
		.next_level     (next_level)
	);

	regs_predecode i_regs_predecode (
		.next_instr    (next_instr),
		.next_level    (next_level),
		.next_regs_rs1 (next_regs_rs1),
		.next_regs_rs2 (next_regs_rs2),
		.next_regs_vld (next_regs_vld)
	);

endmodule

`default_nettype wire

/* hw/regs_predecode.sv */
// rs1 and rs2 numbers of the instruction that the CIR will hold next cycle
// purely combinational, the numbers are only meaningful when next_regs_vld is high
`timescale 1ns/1ps
`default_nettype none

module regs_predecode import fetch_pkg::*; import instr_pkg::*; (
	input  wire instr_view_u next_instr,
	input  wire hw_count_t   next_level,
	output reg_num_t         next_regs_rs1,
	output reg_num_t         next_regs_rs2,
	output logic             next_regs_vld
);

	quadrant_e quadrant;
	logic [2:0] funct3;
	logic       is_32bit;

	assign quadrant = next_instr.rvc.quadrant;
	assign funct3   = next_instr.rvc.funct3;
	assign is_32bit = quadrant == QUAD_3;

	// a 32-bit instruction needs both CIR halfwords, a compressed one only the low
	assign next_regs_vld = is_32bit ? next_level[1] : |next_level;

	always_comb begin
		// compact register fields address x8 to x15
		next_regs_rs1 = {2'b01, next_instr.rvc.rd_rs1.compact};
		if (is_32bit) begin
			next_regs_rs1 = next_instr.rv32.rs1;
		end else if ((quadrant == QUAD_0 && funct3 == 3'b000)
			|| (quadrant == QUAD_1 && funct3 == 3'b011)
			|| (quadrant == QUAD_2 && (funct3 == 3'b010 || funct3 == 3'b110))) begin
			// addi4spn, addi16sp, lwsp and swsp all work off the stack pointer
			next_regs_rs1 = 5'd2;
		end else if (quadrant == QUAD_2 || (quadrant == QUAD_1 && funct3 == 3'b000)) begin
			next_regs_rs1 = next_instr.rvc.rd_rs1;
		end
	end

	always_comb begin
		if (is_32bit) begin
			next_regs_rs2 = next_instr.rv32.rs2;
		end else if (quadrant == QUAD_2) begin
			next_regs_rs2 = next_instr.rvc.rs2;
		end else begin
			next_regs_rs2 = {2'b01, next_instr.rvc.rs2.compact};
		end
	end

endmodule

`default_nettype wire

/* hw/assembly/instr_assembly.sv */
// instruction assembly yard of three halfwords, the CIR plus one buffer halfword
// decode consumption may not exceed cir_vld
// fetch words always land whole, since jump targets are word aligned
`timescale 1ns/1ps
`default_nettype none

module instr_assembly import fetch_pkg::*; import instr_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire word_t     fetch_data,
	input  wire logic      fetch_data_vld,
	input  wire logic      jump_now,
	input  wire logic      flushing,
	input  wire hw_count_t cir_use,
	output word_t          cir,
	output hw_count_t      cir_vld,
	output logic           must_refill,
	output instr_view_u    next_instr,
	output hw_count_t      next_level
);

	// number of valid halfwords in {hwbuf, cir}
	hw_count_t       level;
	half_t           hwbuf;
	half_t [2:0]     yard;
	half_t [2:0]     yard_shifted;
	half_t [2:0]     yard_next;
	hw_count_t       level_no_fetch;
	hw_count_t       level_next;
	logic            refill_now;

	assign yard = {hwbuf, cir};

	// ------------------------------------------------------------
	// shift by consumption
	// ------------------------------------------------------------

	// halfwords that end up invalid or overwritten are left as whatever is
	// cheapest, only the surviving ones need to move down
	always_comb begin
		if (cir_use[1]) begin
			yard_shifted = {hwbuf, yard[1], hwbuf};
		end else if (cir_use[0]) begin
			yard_shifted = {hwbuf, hwbuf, yard[1]};
		end else begin
			yard_shifted = yard;
		end
	end

	assign level_no_fetch = level - cir_use;

	// ------------------------------------------------------------
	// fetch overlay
	// ------------------------------------------------------------

	// the yard wants a new word whenever less than two halfwords survive
	assign must_refill = !level_no_fetch[1];
	assign refill_now  = must_refill && fetch_data_vld;

	// the fresh word sits right above the surviving halfwords, and is laid down
	// even when not valid since the level decides what counts
	always_comb begin
		if (level_no_fetch[1]) begin
			yard_next = yard_shifted;
		end else if (level_no_fetch[0]) begin
			yard_next = {fetch_data, yard_shifted[0]};
		end else begin
			yard_next = {yard_shifted[2], fetch_data};
		end
	end

	// a redirect throws away everything, including a word arriving now
	assign level_next = (jump_now || flushing) ? 2'd0 : level_no_fetch + {refill_now, 1'b0};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level   <= '0;
			cir_vld <= '0;
		end else begin
			level   <= level_next;
			// decode never sees more than the CIR itself
			cir_vld <= level_next[1] ? 2'd2 : level_next;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= yard_next;
	end

	// the predecode looks at next cycle's CIR
	assign next_instr = yard_next[1:0];
	assign next_level = level_next;

endmodule

`default_nettype wire

/* hw/fetch/prefetch_queue.sv */
// shift style prefetch queue, entry 0 is always the head
// when empty the bus word is offered straight to assembly and not stored
`timescale 1ns/1ps
`default_nettype none

`include "frontend_macros.svh"

module prefetch_queue import fetch_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire word_t mem_data,
	input  wire logic  mem_data_vld,
	input  wire logic  flushing,
	input  wire logic  jump_now,
	input  wire logic  must_refill,
	output logic       full,
	output logic       almost_full,
	output logic       empty,
	output word_t      fetch_data,
	output logic       fetch_data_vld
);

	localparam int DEPTH = `FE_FIFO_DEPTH;

	word_t            entry [DEPTH];
	logic [DEPTH-1:0] valid;
	logic             push;
	logic             pop;

	assign full        = valid[DEPTH-1];
	assign almost_full = !valid[DEPTH-1] && valid[DEPTH-2];
	assign empty       = !valid[0];

	// a word bypassing an empty queue into the yard is not stored as well
	assign push = mem_data_vld && !flushing && !(must_refill && empty);
	assign pop  = must_refill && !empty;

	// the yard sees the head, or the live bus word when nothing is queued
	assign fetch_data     = empty ? mem_data : entry[0];
	assign fetch_data_vld = !empty || (mem_data_vld && !flushing);

	// valid bits stay packed at the bottom, so push fills one more and pop drops one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (jump_now) begin
			valid <= '0;
		end else if (push || pop) begin
			valid <= ~(~valid << push) >> pop;
		end
	end

	// ------------------------------------------------------------
	// data shift
	// ------------------------------------------------------------

	// each entry takes its upper neighbour on a pop, otherwise the bus word
	// lands in the lowest free slot
	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			if (pop || (push && !valid[i])) begin
				if (i < DEPTH - 1 && valid[(i + 1) % DEPTH]) begin
					entry[i] <= entry[(i + 1) % DEPTH];
				end else begin
					entry[i] <= mem_data;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/fetch/fetch_request.sv */
// address phase generator for the instruction bus
// jump targets must be word aligned, all accesses are full words
// once mem_addr_vld is up the address holds until the cycle after mem_addr_rdy
`timescale 1ns/1ps
`default_nettype none

`include "frontend_macros.svh"

module fetch_request import fetch_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst_n,
	output addr_t      mem_addr,
	output logic       mem_addr_vld,
	input  wire logic  mem_addr_rdy,
	input  wire logic  mem_data_vld,
	input  wire addr_t jump_target,
	input  wire logic  jump_target_vld,
	output logic       jump_target_rdy,
	input  wire logic  queue_full,
	input  wire logic  queue_almost_full,
	output logic       jump_now,
	output logic       flushing
);

	addr_t        fetch_addr;
	logic         addr_hold;
	logic         reset_holdoff;
	fetch_count_t pending;
	fetch_count_t flush_cnt;
	logic         addr_vld_raw;
	logic         accepted;
	logic         new_issue;
	logic         fetch_stall;

	// ------------------------------------------------------------
	// handshake state
	// ------------------------------------------------------------

	// a held address phase blocks redirection, everything else may jump
	assign jump_target_rdy = !addr_hold;
	assign jump_now        = jump_target_vld && jump_target_rdy;
	assign accepted        = mem_addr_vld && mem_addr_rdy;
	// a fetch counts as pending from the first cycle its address is shown
	assign new_issue       = mem_addr_vld && !addr_hold;
	// returning words are dropped while older fetches are still draining
	assign flushing        = |flush_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff <= 1'b1;
			addr_hold     <= 1'b0;
			pending       <= '0;
			flush_cnt     <= '0;
		end else begin
			reset_holdoff <= 1'b0;
			addr_hold     <= mem_addr_vld && !mem_addr_rdy;
			pending       <= pending + fetch_count_t'(new_issue) - fetch_count_t'(mem_data_vld);
			if (jump_now) begin
				// everything in flight now belongs to the old stream
				flush_cnt <= pending - fetch_count_t'(mem_data_vld);
			end else if (flushing && mem_data_vld) begin
				flush_cnt <= flush_cnt - 2'd1;
			end
		end
	end

	// ------------------------------------------------------------
	// fetch address
	// ------------------------------------------------------------

	// the fetch address runs ahead of decode in word steps
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= `FE_RESET_VECTOR;
		end else if (jump_now) begin
			// step past the target if it went out on the bus this cycle
			fetch_addr <= {jump_target[`FE_W_ADDR-1:2] + (`FE_W_ADDR-2)'(accepted), 2'b00};
		end else if (accepted) begin
			fetch_addr <= fetch_addr + addr_t'(4);
		end
	end

	// the registered pending count keeps bus ready out of the address path
	assign fetch_stall = queue_full
		|| (queue_almost_full && |pending)
		|| pending > 2'd1;

	// priority is a held address, then a jump target, then the next word
	always_comb begin
		mem_addr     = fetch_addr;
		addr_vld_raw = 1'b1;
		if (addr_hold) begin
			mem_addr = fetch_addr;
		end else if (jump_target_vld) begin
			mem_addr = jump_target;
		end else if (fetch_stall) begin
			addr_vld_raw = 1'b0;
		end
	end

	// no request goes out in the first cycle after reset
	assign mem_addr_vld = addr_vld_raw && !reset_holdoff;

endmodule

`default_nettype wire

/* common/instr_pkg.sv */
// instruction side types, the two encodings share one 32-bit word
// the two lowest bits pick which view of the union is meaningful
`default_nettype none

package instr_pkg;

	// register number in the integer register file
	typedef logic [4:0] reg_num_t;

	// the two lowest instruction bits, quadrant 3 is a 32-bit instruction
	typedef enum logic [1:0] {
		QUAD_0 = 2'b00,
		QUAD_1 = 2'b01,
		QUAD_2 = 2'b10,
		QUAD_3 = 2'b11
	} quadrant_e;

	// standard 32-bit field layout, opcode includes the quadrant bits
	typedef struct packed {
		logic [6:0] funct7;
		reg_num_t   rs2;
		reg_num_t   rs1;
		logic [2:0] funct3;
		reg_num_t   rd;
		logic [6:0] opcode;
	} rv32_fields_t;

	// a full compressed register field, whose low three bits are the compact
	// register field of the CA/CB/CL/CS formats (x8 to x15)
	typedef struct packed {
		logic [1:0] prefix;
		logic [2:0] compact;
	} rvc_reg_t;

	// compressed layout in the low halfword, upper halfword unused
	typedef struct packed {
		logic [15:0] upper;
		logic [2:0]  funct3;
		logic        bit12;
		rvc_reg_t    rd_rs1;
		rvc_reg_t    rs2;
		quadrant_e   quadrant;
	} rvc_fields_t;

	// one instruction word seen either way
	typedef union packed {
		rv32_fields_t rv32;
		rvc_fields_t  rvc;
	} instr_view_u;

endpackage

`default_nettype wire

/* common/fetch_pkg.sv */
// fetch side types for the bus and the instruction assembly yard
// widths come from the front end macro header
`default_nettype none

`include "frontend_macros.svh"

package fetch_pkg;

	// ------------------------------------------------------------
	// bus side
	// ------------------------------------------------------------

	// byte address on the instruction bus
	typedef logic [`FE_W_ADDR-1:0] addr_t;

	// one data word as returned by the bus
	typedef logic [`FE_W_DATA-1:0] word_t;

	// ------------------------------------------------------------
	// assembly side
	// ------------------------------------------------------------

	// one instruction halfword, the unit decode consumes
	typedef logic [`FE_W_DATA/2-1:0] half_t;

	// halfword count from 0 to 3, used for the yard level and for consumption
	typedef logic [1:0] hw_count_t;

	// number of fetches in flight, never more than two in normal operation
	typedef logic [1:0] fetch_count_t;

endpackage

`default_nettype wire

/* common/frontend_macros.svh */
// widths, queue depth and reset vector for the fetch front end
// the queue depth must be a power of two and at least 2
// the reset vector must be word aligned since fetches are whole words
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// ------------------------------------------------------------
// bus geometry
// ------------------------------------------------------------

// byte address width of the instruction bus
`define FE_W_ADDR 32

// data word width, two instruction halfwords per word
`define FE_W_DATA 32

// ------------------------------------------------------------
// front end configuration
// ------------------------------------------------------------

// number of words held in the prefetch queue
`define FE_FIFO_DEPTH 2

// first fetch address after reset
`define FE_RESET_VECTOR 32'h0000_0080

`endif
